// ==== hdl/axil_word_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_word_master
	import dcache_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_rst,
	mem_word_if.master mw,
	output logic o_awvalid,
	input wire logic i_awready,
	output word_t o_awaddr,
	output logic o_wvalid,
	input wire logic i_wready,
	output word_t o_wdata,
	output strb_t o_wstrb,
	input wire logic i_bvalid,
	output logic o_bready,
	input wire logic [1:0] i_bresp,
	output logic o_arvalid,
	input wire logic i_arready,
	output word_t o_araddr,
	input wire logic i_rvalid,
	output logic o_rready,
	input wire word_t i_rdata,
	input wire logic [1:0] i_rresp
);

	logic r_done;
	word_t r_rdata;
	logic w_busy;
	logic w_start;

	// response codes are not checked, every word is taken as done
	assign w_busy = o_awvalid | o_wvalid | o_bready | o_arvalid | o_rready;
	assign w_start = mw.req_valid && !w_busy && !r_done;
	assign o_wstrb = '1;
	assign mw.done = r_done;
	assign mw.rdata = r_rdata;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_awvalid <= 1'b0;
			o_wvalid <= 1'b0;
			o_bready <= 1'b0;
			o_arvalid <= 1'b0;
			o_rready <= 1'b0;
			r_done <= 1'b0;
		end else begin
			r_done <= 1'b0;
			if (w_start && mw.req_write) begin
				o_awvalid <= 1'b1;
				o_wvalid <= 1'b1;
				o_bready <= 1'b1;
			end
			if (w_start && !mw.req_write) begin
				o_arvalid <= 1'b1;
				o_rready <= 1'b1;
			end
			// address and data channels finish on their own
			if (o_awvalid && i_awready) begin
				o_awvalid <= 1'b0;
			end
			if (o_wvalid && i_wready) begin
				o_wvalid <= 1'b0;
			end
			if (o_arvalid && i_arready) begin
				o_arvalid <= 1'b0;
			end
			if ((o_bready && i_bvalid) || (o_rready && i_rvalid)) begin
				o_bready <= 1'b0;
				o_rready <= 1'b0;
				r_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_start) begin
			o_awaddr <= mw.req_addr;
			o_araddr <= mw.req_addr;
			o_wdata <= mw.req_wdata;
		end
		if (o_rready && i_rvalid) begin
			r_rdata <= i_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module data_store
	import dcache_pkg::*;
(
	input wire logic i_clk,
	input wire idx_t i_rd_idx,
	input wire ofs_t i_rd_ofs,
	input wire logic i_wr_en,
	input wire way_t i_wr_way,
	input wire idx_t i_wr_idx,
	input wire ofs_t i_wr_ofs,
	input wire strb_t i_wr_strb,
	input wire word_t i_wr_data,
	output word_t [`DC_WAYS-1:0] o_rd_data
);

	localparam int DEPTH = `DC_SETS * `DC_WORDS_PER_LINE;

	word_t r_mem [`DC_WAYS][DEPTH];
	logic [`DC_IDX_W+`DC_OFS_W-1:0] w_rd_addr;
	logic [`DC_IDX_W+`DC_OFS_W-1:0] w_wr_addr;

	assign w_rd_addr = {i_rd_idx, i_rd_ofs};
	assign w_wr_addr = {i_wr_idx, i_wr_ofs};

	always_ff @(posedge i_clk) begin
		// every way is read, the controller picks one
		for (int w = 0; w < `DC_WAYS; w++) begin
			o_rd_data[w] <= r_mem[w][w_rd_addr];
		end
		if (i_wr_en) begin
			for (int b = 0; b < `DC_ADDR_W/8; b++) begin
				if (i_wr_strb[b]) begin
					r_mem[i_wr_way][w_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address and data word width
`define DC_ADDR_W 32

// cache geometry
`define DC_WORDS_PER_LINE 4
`define DC_WAYS 4
`define DC_SETS 8

// address split: tag | index | word | byte
`define DC_OFS_W 2
`define DC_IDX_W 3
`define DC_TAG_W 25

// tree bits for four ways
`define DC_PLRU_W 3

`endif

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_req_valid,
	output logic o_req_ready,
	input wire word_t i_req_addr,
	input wire strb_t i_req_wstrb,
	input wire word_t i_req_wdata,
	output logic o_rsp_valid,
	output word_t o_rsp_rdata,
	output idx_t o_tag_rd_idx,
	output tag_t o_tag_rd_tag,
	output logic o_tag_wr_en,
	output way_t o_tag_wr_way,
	output idx_t o_tag_wr_idx,
	output tag_t o_tag_wr_tag,
	output logic o_tag_wr_valid,
	input wire logic i_hit,
	input wire way_t i_hit_way,
	input wire tag_t [`DC_WAYS-1:0] i_victim_tag,
	input wire logic [`DC_WAYS-1:0] i_victim_valid,
	output idx_t o_data_rd_idx,
	output ofs_t o_data_rd_ofs,
	output logic o_data_wr_en,
	output way_t o_data_wr_way,
	output idx_t o_data_wr_idx,
	output ofs_t o_data_wr_ofs,
	output strb_t o_data_wr_strb,
	output word_t o_data_wr_data,
	input wire word_t [`DC_WAYS-1:0] i_rd_data,
	output idx_t o_plru_idx,
	output logic o_plru_touch,
	output way_t o_plru_touch_way,
	input wire way_t i_victim_way,
	mem_word_if.ctrl mw
);

	dc_state_e r_state;
	dc_state_e w_next;
	idx_t r_sweep_cnt;
	ofs_t r_cnt;
	word_t r_addr;
	word_t r_wdata;
	strb_t r_strb;
	way_t r_vway;
	tag_t r_vtag;
	tag_t w_tag;
	idx_t w_idx;
	ofs_t w_ofs;
	word_t w_sel_addr;
	word_t w_hit_word;
	logic w_last;
	logic w_evicting;
	logic w_refill_wr;

	// fields of the saved request
	assign w_tag = r_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign w_idx = r_addr[2+`DC_OFS_W +: `DC_IDX_W];
	assign w_ofs = r_addr[2 +: `DC_OFS_W];
	assign w_last = (r_cnt == ofs_t'(`DC_WORDS_PER_LINE-1));
	assign w_evicting = (r_state == EVICT_RD) || (r_state == EVICT_WR);
	assign w_refill_wr = (r_state == REFILL) && mw.done;

	always_comb begin
		w_next = r_state;
		case (r_state)
			SWEEP: if (r_sweep_cnt == idx_t'(`DC_SETS-1)) w_next = IDLE;
			IDLE: if (i_req_valid) w_next = LOOKUP;
			LOOKUP: begin
				if (i_hit) begin
					w_next = IDLE;
				end else if (i_victim_valid[i_victim_way]) begin
					w_next = EVICT_RD;
				end else begin
					w_next = REFILL;
				end
			end
			EVICT_RD: w_next = EVICT_WR;
			EVICT_WR: if (mw.done) w_next = w_last ? REFILL : EVICT_RD;
			REFILL: if (mw.done && w_last) w_next = COMMIT;
			COMMIT: w_next = LOOKUP;
			default: w_next = SWEEP;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= SWEEP;
			r_sweep_cnt <= '0;
			r_cnt <= '0;
		end else begin
			r_state <= w_next;
			if (r_state == SWEEP) begin
				r_sweep_cnt <= r_sweep_cnt + 1'b1;
			end
			// wraps to zero after the last evicted word
			if (r_state == LOOKUP) begin
				r_cnt <= '0;
			end else if (mw.done) begin
				r_cnt <= r_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_req_ready && i_req_valid) begin
			r_addr <= i_req_addr;
			r_strb <= i_req_wstrb;
			r_wdata <= i_req_wdata;
		end
		if (r_state == LOOKUP) begin
			r_vway <= i_victim_way;
			r_vtag <= i_victim_tag[i_victim_way];
		end
	end

	assign o_req_ready = (r_state == IDLE);

	// store reads: new request in IDLE, saved one on replay
	assign w_sel_addr = o_req_ready ? i_req_addr : r_addr;
	assign o_tag_rd_idx = w_sel_addr[2+`DC_OFS_W +: `DC_IDX_W];
	assign o_tag_rd_tag = w_sel_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign o_data_rd_idx = o_tag_rd_idx;
	assign o_data_rd_ofs = w_evicting ? r_cnt : w_sel_addr[2 +: `DC_OFS_W];

	assign o_tag_wr_en = (r_state == SWEEP) || (r_state == COMMIT);
	assign o_tag_wr_way = r_vway;
	assign o_tag_wr_idx = (r_state == SWEEP) ? r_sweep_cnt : w_idx;
	assign o_tag_wr_tag = w_tag;
	assign o_tag_wr_valid = (r_state == COMMIT);

	// refill words or a store hit share the write port
	assign o_data_wr_en = w_refill_wr || (o_rsp_valid && |r_strb);
	assign o_data_wr_way = w_refill_wr ? r_vway : i_hit_way;
	assign o_data_wr_idx = w_idx;
	assign o_data_wr_ofs = w_refill_wr ? r_cnt : w_ofs;
	assign o_data_wr_strb = w_refill_wr ? '1 : r_strb;
	assign o_data_wr_data = w_refill_wr ? mw.rdata : r_wdata;

	assign o_rsp_valid = (r_state == LOOKUP) && i_hit;
	assign w_hit_word = i_rd_data[i_hit_way];

	always_comb begin
		for (int b = 0; b < `DC_ADDR_W/8; b++) begin
			o_rsp_rdata[8*b +: 8] = r_strb[b] ? r_wdata[8*b +: 8] : w_hit_word[8*b +: 8];
		end
	end

	assign o_plru_idx = w_idx;
	assign o_plru_touch = o_rsp_valid || (r_state == COMMIT);
	assign o_plru_touch_way = (r_state == COMMIT) ? r_vway : i_hit_way;

	// victim words go to the old line address, refill reads the new one
	assign mw.req_valid = (r_state == EVICT_WR) || (r_state == REFILL);
	assign mw.req_write = (r_state == EVICT_WR);
	assign mw.req_addr = (r_state == EVICT_WR) ? {r_vtag, w_idx, r_cnt, 2'b00}
		: {w_tag, w_idx, r_cnt, 2'b00};
	assign mw.req_wdata = i_rd_data[r_vway];

endmodule

`default_nettype wire

// ==== hdl/dcache_pkg.sv ====
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

	typedef logic [`DC_ADDR_W-1:0] word_t;
	typedef logic [`DC_ADDR_W/8-1:0] strb_t;
	typedef logic [`DC_TAG_W-1:0] tag_t;
	typedef logic [`DC_IDX_W-1:0] idx_t;
	typedef logic [`DC_OFS_W-1:0] ofs_t;
	typedef logic [1:0] way_t;
	typedef logic [`DC_PLRU_W-1:0] plru_t;

	// controller states
	typedef enum logic [2:0] {
		SWEEP,
		IDLE,
		LOOKUP,
		EVICT_RD,
		EVICT_WR,
		REFILL,
		COMMIT
	} dc_state_e;

endpackage

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top
	import dcache_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_req_valid,
	output logic o_req_ready,
	input wire word_t i_req_addr,
	input wire strb_t i_req_wstrb,
	input wire word_t i_req_wdata,
	output logic o_rsp_valid,
	output word_t o_rsp_rdata,
	output logic o_awvalid,
	input wire logic i_awready,
	output word_t o_awaddr,
	output logic o_wvalid,
	input wire logic i_wready,
	output word_t o_wdata,
	output strb_t o_wstrb,
	input wire logic i_bvalid,
	output logic o_bready,
	input wire logic [1:0] i_bresp,
	output logic o_arvalid,
	input wire logic i_arready,
	output word_t o_araddr,
	input wire logic i_rvalid,
	output logic o_rready,
	input wire word_t i_rdata,
	input wire logic [1:0] i_rresp
);

	// tag store
	idx_t tag_rd_idx;
	tag_t tag_rd_tag;
	logic tag_wr_en;
	way_t tag_wr_way;
	idx_t tag_wr_idx;
	tag_t tag_wr_tag;
	logic tag_wr_valid;
	logic hit;
	way_t hit_way;
	tag_t [`DC_WAYS-1:0] victim_tag;
	logic [`DC_WAYS-1:0] victim_valid;

	// data store
	idx_t data_rd_idx;
	ofs_t data_rd_ofs;
	logic data_wr_en;
	way_t data_wr_way;
	idx_t data_wr_idx;
	ofs_t data_wr_ofs;
	strb_t data_wr_strb;
	word_t data_wr_data;
	word_t [`DC_WAYS-1:0] rd_data;

	// replacement
	idx_t plru_idx;
	logic plru_touch;
	way_t plru_touch_way;
	way_t victim_way;

	mem_word_if mem_bus ();

	tag_store i_tag_store (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_rd_idx(tag_rd_idx),
		.i_rd_tag(tag_rd_tag),
		.i_wr_en(tag_wr_en),
		.i_wr_way(tag_wr_way),
		.i_wr_idx(tag_wr_idx),
		.i_wr_tag(tag_wr_tag),
		.i_wr_valid(tag_wr_valid),
		.o_hit(hit),
		.o_hit_way(hit_way),
		.o_victim_tag(victim_tag),
		.o_victim_valid(victim_valid)
	);

	data_store i_data_store (
		.i_clk(i_clk),
		.i_rd_idx(data_rd_idx),
		.i_rd_ofs(data_rd_ofs),
		.i_wr_en(data_wr_en),
		.i_wr_way(data_wr_way),
		.i_wr_idx(data_wr_idx),
		.i_wr_ofs(data_wr_ofs),
		.i_wr_strb(data_wr_strb),
		.i_wr_data(data_wr_data),
		.o_rd_data(rd_data)
	);

	plru_store i_plru_store (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_idx(plru_idx),
		.i_touch(plru_touch),
		.i_touch_way(plru_touch_way),
		.o_victim_way(victim_way)
	);

	dcache_ctrl i_ctrl (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req_valid(i_req_valid),
		.o_req_ready(o_req_ready),
		.i_req_addr(i_req_addr),
		.i_req_wstrb(i_req_wstrb),
		.i_req_wdata(i_req_wdata),
		.o_rsp_valid(o_rsp_valid),
		.o_rsp_rdata(o_rsp_rdata),
		.o_tag_rd_idx(tag_rd_idx),
		.o_tag_rd_tag(tag_rd_tag),
		.o_tag_wr_en(tag_wr_en),
		.o_tag_wr_way(tag_wr_way),
		.o_tag_wr_idx(tag_wr_idx),
		.o_tag_wr_tag(tag_wr_tag),
		.o_tag_wr_valid(tag_wr_valid),
		.i_hit(hit),
		.i_hit_way(hit_way),
		.i_victim_tag(victim_tag),
		.i_victim_valid(victim_valid),
		.o_data_rd_idx(data_rd_idx),
		.o_data_rd_ofs(data_rd_ofs),
		.o_data_wr_en(data_wr_en),
		.o_data_wr_way(data_wr_way),
		.o_data_wr_idx(data_wr_idx),
		.o_data_wr_ofs(data_wr_ofs),
		.o_data_wr_strb(data_wr_strb),
		.o_data_wr_data(data_wr_data),
		.i_rd_data(rd_data),
		.o_plru_idx(plru_idx),
		.o_plru_touch(plru_touch),
		.o_plru_touch_way(plru_touch_way),
		.i_victim_way(victim_way),
		.mw(mem_bus)
	);

	axil_word_master i_axil_master (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.mw(mem_bus),
		.o_awvalid(o_awvalid),
		.i_awready(i_awready),
		.o_awaddr(o_awaddr),
		.o_wvalid(o_wvalid),
		.i_wready(i_wready),
		.o_wdata(o_wdata),
		.o_wstrb(o_wstrb),
		.i_bvalid(i_bvalid),
		.o_bready(o_bready),
		.i_bresp(i_bresp),
		.o_arvalid(o_arvalid),
		.i_arready(i_arready),
		.o_araddr(o_araddr),
		.i_rvalid(i_rvalid),
		.o_rready(o_rready),
		.i_rdata(i_rdata),
		.i_rresp(i_rresp)
	);

endmodule

`default_nettype wire

// ==== hdl/mem_word_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one word per request, req_valid held until done
interface mem_word_if import dcache_pkg::*; ();

	logic req_valid;
	logic req_write;
	word_t req_addr;
	word_t req_wdata;
	logic done;
	word_t rdata;

	modport ctrl (
		output req_valid, req_write, req_addr, req_wdata,
		input done, rdata
	);

	modport master (
		input req_valid, req_write, req_addr, req_wdata,
		output done, rdata
	);

endinterface

`default_nettype wire

// ==== hdl/plru_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module plru_store
	import dcache_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_rst,
	input wire idx_t i_idx,
	input wire logic i_touch,
	input wire way_t i_touch_way,
	output way_t o_victim_way
);

	// bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
	plru_t r_bits [`DC_SETS];
	plru_t w_cur;
	plru_t w_next;

	assign w_cur = r_bits[i_idx];

	always_comb begin
		if (w_cur[0]) begin
			o_victim_way = {1'b1, w_cur[2]};
		end else begin
			o_victim_way = {1'b0, w_cur[1]};
		end
	end

	// point root and the touched half's leaf away from the touched way
	always_comb begin
		w_next = w_cur;
		w_next[0] = ~i_touch_way[1];
		if (i_touch_way[1]) begin
			w_next[2] = ~i_touch_way[0];
		end else begin
			w_next[1] = ~i_touch_way[0];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				r_bits[s] <= '0;
			end
		end else if (i_touch) begin
			r_bits[i_idx] <= w_next;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module tag_store
	import dcache_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_rst,
	input wire idx_t i_rd_idx,
	input wire tag_t i_rd_tag,
	input wire logic i_wr_en,
	input wire way_t i_wr_way,
	input wire idx_t i_wr_idx,
	input wire tag_t i_wr_tag,
	input wire logic i_wr_valid,
	output logic o_hit,
	output way_t o_hit_way,
	output tag_t [`DC_WAYS-1:0] o_victim_tag,
	output logic [`DC_WAYS-1:0] o_victim_valid
);

	tag_t r_tag_mem [`DC_WAYS][`DC_SETS];
	logic [`DC_SETS-1:0] r_vld_mem [`DC_WAYS];
	idx_t r_rd_idx;
	tag_t r_rd_tag;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_rd_idx <= '0;
			r_rd_tag <= '0;
		end else begin
			r_rd_idx <= i_rd_idx;
			r_rd_tag <= i_rd_tag;
		end
	end

	// a write without valid clears the whole set, used by the sweep
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			if (i_wr_valid) begin
				r_tag_mem[i_wr_way][i_wr_idx] <= i_wr_tag;
				r_vld_mem[i_wr_way][i_wr_idx] <= 1'b1;
			end else begin
				for (int w = 0; w < `DC_WAYS; w++) begin
					r_vld_mem[w][i_wr_idx] <= 1'b0;
				end
			end
		end
	end

	// compare all ways at once
	always_comb begin
		o_hit = 1'b0;
		o_hit_way = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			o_victim_tag[w] = r_tag_mem[w][r_rd_idx];
			o_victim_valid[w] = r_vld_mem[w][r_rd_idx];
			if (r_vld_mem[w][r_rd_idx] && r_tag_mem[w][r_rd_idx] == r_rd_tag) begin
				o_hit = 1'b1;
				o_hit_way = way_t'(w);
			end
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -f sources.f --top-module tb_dcache -o tb_dcache_sim || exit 1
./obj_dir/tb_dcache_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1

// ==== sources.f ====
+incdir+hdl
hdl/dcache_pkg.sv
hdl/mem_word_if.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/plru_store.sv
hdl/axil_word_master.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/axil_mem_model.sv
tb/tb_dcache.sv

// ==== tb/axil_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_awvalid,
	output logic o_awready,
	input wire logic [31:0] i_awaddr,
	input wire logic i_wvalid,
	output logic o_wready,
	input wire logic [31:0] i_wdata,
	input wire logic [3:0] i_wstrb,
	output logic o_bvalid,
	input wire logic i_bready,
	output logic [1:0] o_bresp,
	input wire logic i_arvalid,
	output logic o_arready,
	input wire logic [31:0] i_araddr,
	output logic o_rvalid,
	input wire logic i_rready,
	output logic [31:0] o_rdata,
	output logic [1:0] o_rresp
);

	// word array, indexed by byte address bits 11:2
	logic [31:0] mem [1024];
	logic [31:0] r_awaddr;
	logic [31:0] r_wdata;
	logic r_aw_got;
	logic r_w_got;
	logic [1:0] r_aw_dly;
	logic [1:0] r_w_dly;
	logic [1:0] r_ar_dly;

	assign o_bresp = 2'b00;
	assign o_rresp = 2'b00;

	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = 32'(i * 4) ^ 32'h5a5a_0000;
		end
	end

	always @(posedge i_clk) begin
		if (i_rst) begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_arready <= 1'b0;
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
			r_aw_got <= 1'b0;
			r_w_got <= 1'b0;
			r_aw_dly <= 2'd0;
			r_w_dly <= 2'd0;
			r_ar_dly <= 2'd0;
		end else begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_arready <= 1'b0;
			// ready comes after a random wait of 0 to 3 cycles
			if (i_awvalid && o_awready) begin
				r_awaddr <= i_awaddr;
				r_aw_got <= 1'b1;
				r_aw_dly <= 2'($urandom % 4);
			end else if (i_awvalid && !r_aw_got) begin
				if (r_aw_dly == 2'd0) begin
					o_awready <= 1'b1;
				end else begin
					r_aw_dly <= r_aw_dly - 2'd1;
				end
			end
			if (i_wvalid && o_wready) begin
				r_wdata <= i_wdata;
				r_w_got <= 1'b1;
				r_w_dly <= 2'($urandom % 4);
			end else if (i_wvalid && !r_w_got) begin
				if (r_w_dly == 2'd0) begin
					o_wready <= 1'b1;
				end else begin
					r_w_dly <= r_w_dly - 2'd1;
				end
			end
			if (o_bvalid && i_bready) begin
				o_bvalid <= 1'b0;
			end
			// both halves of the write are in, commit the word
			if (r_aw_got && r_w_got && !o_bvalid) begin
				for (int b = 0; b < 4; b++) begin
					if (i_wstrb[b]) begin
						mem[r_awaddr[11:2]][8*b +: 8] <= r_wdata[8*b +: 8];
					end
				end
				o_bvalid <= 1'b1;
				r_aw_got <= 1'b0;
				r_w_got <= 1'b0;
			end
			if (o_rvalid && i_rready) begin
				o_rvalid <= 1'b0;
			end
			if (i_arvalid && o_arready) begin
				o_rvalid <= 1'b1;
				o_rdata <= mem[i_araddr[11:2]];
				r_ar_dly <= 2'($urandom % 4);
			end else if (i_arvalid && !o_rvalid) begin
				if (r_ar_dly == 2'd0) begin
					o_arready <= 1'b1;
				end else begin
					r_ar_dly <= r_ar_dly - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	localparam logic [31:0] SEED = 32'h7d25_a6c1;
	localparam int N = 23;
	localparam int TIMEOUT = 400 * N;

	// set 1 takes a cold miss, hits and strobed stores
	// set 2 gets five tags so the fifth evicts the first, which then comes back
	// set 3 fills ways 0, 2, 1 and 3 in turn
	// touching A again makes B the victim
	localparam logic [31:0] T_ADDR [N] = '{
		32'h010, 32'h014, 32'h01c, 32'h018, 32'h014, 32'h018, 32'h014,
		32'h020, 32'h0a0, 32'h120, 32'h1a0, 32'h220, 32'h020,
		32'h030, 32'h0b0, 32'h130, 32'h1b0, 32'h030, 32'h230,
		32'h034, 32'h138, 32'h1b4, 32'h0b0};
	localparam logic [3:0] T_STRB [N] = '{
		4'h0, 4'h0, 4'h0, 4'h3, 4'h8, 4'h0, 4'h0,
		4'hf, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h0, 4'h0, 4'h0};
	localparam logic [31:0] T_DATA [N] = '{
		32'h0, 32'h0, 32'h0, 32'haabb_ccdd, 32'h1122_3344, 32'h0, 32'h0,
		32'hcafe_f00d, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
		32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
		32'h0, 32'h0, 32'h0, 32'h0};
	localparam int T_AR [N] = '{4, 0, 0, 0, 0, 0, 0, 4, 4, 4, 4, 4, 4,
		4, 4, 4, 4, 0, 4, 0, 0, 0, 4};
	localparam int T_AW [N] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 4, 4,
		0, 0, 0, 0, 0, 4, 0, 0, 0, 4};

	logic i_clk;
	logic i_rst;
	logic i_req_valid;
	logic o_req_ready;
	logic [31:0] i_req_addr;
	logic [3:0] i_req_wstrb;
	logic [31:0] i_req_wdata;
	logic o_rsp_valid;
	logic [31:0] o_rsp_rdata;
	logic awvalid;
	logic awready;
	logic [31:0] awaddr;
	logic wvalid;
	logic wready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [31:0] araddr;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [1:0] rresp;

	logic [31:0] shadow [1024];
	int errors = 0;
	int cycles = 0;
	int ar_total = 0;
	int aw_total = 0;

	dcache_top i_dut (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
		.i_req_addr(i_req_addr), .i_req_wstrb(i_req_wstrb), .i_req_wdata(i_req_wdata),
		.o_rsp_valid(o_rsp_valid), .o_rsp_rdata(o_rsp_rdata),
		.o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr),
		.o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
		.i_bvalid(bvalid), .o_bready(bready), .i_bresp(bresp),
		.o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr),
		.i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata), .i_rresp(rresp)
	);

	axil_mem_model i_mem (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// handshake counters and the hang guard
	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (arvalid && arready) begin
			ar_total <= ar_total + 1;
			check_value("o_araddr[1:0]", 32'(araddr[1:0]), 32'd0);
		end
		if (awvalid && awready) begin
			aw_total <= aw_total + 1;
			check_value("o_awaddr[1:0]", 32'(awaddr[1:0]), 32'd0);
		end
		// every write beat carries the full word
		if (wvalid && wready) begin
			check_value("o_wstrb", 32'(wstrb), 32'hf);
		end
		if (cycles > TIMEOUT) begin
			$display("timeout: the cache stopped responding after %0d cycles", cycles);
			$display("errors: %0d", errors + 1);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic run_entry(input int n);
		int ar_base;
		int aw_base;
		int lat;
		logic [9:0] widx;
		ar_base = ar_total;
		aw_base = aw_total;
		widx = T_ADDR[n][11:2];
		for (int b = 0; b < 4; b++) begin
			if (T_STRB[n][b]) begin
				shadow[widx][8*b +: 8] = T_DATA[n][8*b +: 8];
			end
		end
		@(posedge i_clk);
		i_req_valid <= 1'b1;
		i_req_addr <= T_ADDR[n];
		i_req_wstrb <= T_STRB[n];
		i_req_wdata <= T_DATA[n];
		@(negedge i_clk);
		while (!o_req_ready) begin
			@(negedge i_clk);
		end
		@(posedge i_clk);
		i_req_valid <= 1'b0;
		lat = 0;
		do begin
			@(negedge i_clk);
			lat++;
		end while (!o_rsp_valid);
		check_value("o_rsp_rdata", o_rsp_rdata, shadow[widx]);
		check_value("ar handshakes", 32'(ar_total - ar_base), 32'(T_AR[n]));
		check_value("aw handshakes", 32'(aw_total - aw_base), 32'(T_AW[n]));
		if (T_AR[n] == 0) begin
			check_value("hit latency", 32'(lat), 32'd1);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		for (int i = 0; i < 1024; i++) begin
			shadow[i] = 32'(i * 4) ^ 32'h5a5a_0000;
		end
		i_rst = 1'b1;
		i_req_valid = 1'b0;
		i_req_addr = '0;
		i_req_wstrb = '0;
		i_req_wdata = '0;
		repeat (10) @(posedge i_clk);
		i_rst <= 1'b0;
		@(negedge i_clk);
		// sweep still running and the bus idle
		check_value("o_req_ready", 32'(o_req_ready), 32'd0);
		check_value("o_rsp_valid", 32'(o_rsp_valid), 32'd0);
		check_value("o_arvalid", 32'(arvalid), 32'd0);
		check_value("o_awvalid", 32'(awvalid), 32'd0);
		check_value("o_wvalid", 32'(wvalid), 32'd0);
		check_value("o_bready", 32'(bready), 32'd0);
		check_value("o_rready", 32'(rready), 32'd0);
		for (int n = 0; n < N; n++) begin
			run_entry(n);
		end
		$display("errors: %0d over %0d requests", errors, N);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
